// ==== src/link_pkg.sv ====
// ==============================
// Byte link types
// Beats carried from the SPI slave
// through the FIFO to the bridge
// ==============================
`default_nettype none

package link_pkg;

    // One byte as shifted on MOSI or MISO
    typedef logic [7:0] byte_t;

    // Received byte plus frame marker
    typedef struct packed {
        logic  first;   // first byte after chip select fell
        byte_t data;
    } link_beat_t;

endpackage

`default_nettype wire

// ==== src/bus_pkg.sv ====
// ==============================
// Register bus definitions
// Command codes, address map and
// the single-access bus structs
// ==============================
`default_nettype none

package bus_pkg;

    // Host command codes
    localparam logic [7:0] CMD_READ_REQ   = 8'hA1;
    localparam logic [7:0] CMD_WRITE_REQ  = 8'hA2;
    localparam logic [7:0] CMD_READ_RESP  = 8'hA3;
    localparam logic [7:0] CMD_WRITE_RESP = 8'hA4;

    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;

    // Address map
    localparam addr_t ADDR_LED     = 16'h0000;
    localparam addr_t ADDR_VERSION = 16'h0600;

    // Ascii "FC" followed by major and minor revision
    localparam data_t VERSION_WORD = 32'h4643_0100;

    // One register access, valid for a single cycle
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t wdata;
    } bus_req_t;

    // Answer to an access, ack one cycle after valid
    typedef struct packed {
        logic  ack;
        data_t rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== src/spi_byte_link.sv ====
// ==============================
// SPI mode-0 byte link
// Samples the host pins, frames bytes
// into beats and tracks FIFO credits
// ==============================
`default_nettype none

module spi_byte_link #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 i_sys_clk,
    input  logic                 rst_n_i,
    input  logic                 spi_sclk_i,
    input  logic                 spi_cs_n_i,
    input  logic                 spi_mosi_i,
    output logic                 spi_miso_o,
    output logic                 push_o,
    output link_pkg::link_beat_t beat_o,
    input  logic                 credit_i,
    input  link_pkg::byte_t      tx_byte_i,
    input  logic                 tx_load_i
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [3:0]      sclk_sync;
    logic [1:0]      cs_sync;
    logic [1:0]      mosi_sync;
    logic            sclk_rise;
    logic            sclk_fall;
    logic            cs_active;
    logic [2:0]      bit_cnt;
    logic [6:0]      rx_shift;
    logic            first_pend;
    link_pkg::byte_t tx_shift;
    link_pkg::byte_t tx_pend;
    logic            tx_pend_vld;
    logic [CW-1:0]   credits;

    // ==============================
    // Pin synchronisers
    // ==============================
    // Two extra sclk stages delay edge detection so MOSI has settled
    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            sclk_sync <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[2:0], spi_sclk_i};
            cs_sync   <= {cs_sync[0], spi_cs_n_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
        end
    end

    assign sclk_rise = sclk_sync[2] & ~sclk_sync[3];
    assign sclk_fall = ~sclk_sync[2] & sclk_sync[3];
    assign cs_active = ~cs_sync[1];

    // ==============================
    // Byte framing and MISO shifter
    // ==============================
    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            bit_cnt     <= '0;
            first_pend  <= 1'b1;
            push_o      <= 1'b0;
            tx_shift    <= '0;
            tx_pend_vld <= 1'b0;
        end else begin
            push_o <= 1'b0;
            if (tx_load_i) begin
                tx_pend_vld <= 1'b1;
            end
            if (!cs_active) begin
                // Idle bus drops any partial byte and queued response
                bit_cnt     <= '0;
                first_pend  <= 1'b1;
                tx_shift    <= '0;
                tx_pend_vld <= 1'b0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    push_o     <= 1'b1;
                    first_pend <= 1'b0;
                end
            end else if (sclk_fall) begin
                // Falling edge after the eighth bit starts the next byte
                if (bit_cnt == 3'd0) begin
                    tx_shift    <= tx_pend_vld ? tx_pend : '0;
                    tx_pend_vld <= 1'b0;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (tx_load_i) begin
            tx_pend <= tx_byte_i;
        end
        if (cs_active && sclk_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                beat_o.first <= first_pend;
                beat_o.data  <= {rx_shift, mosi_sync[1]};
            end
        end
    end

    assign spi_miso_o = tx_shift[7];

    // Sender side of the credit loop, one credit back per FIFO pop
    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            credits <= CW'(FIFO_DEPTH);
        end else begin
            credits <= credits - CW'(push_o) + CW'(credit_i);
        end
    end

    // SPI cannot stall, so a push without credit means data loss
    a_push_has_credit : assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        push_o |-> (credits != '0));

endmodule

`default_nettype wire

// ==== src/byte_fifo.sv ====
// ==============================
// Byte FIFO
// Circular beat buffer that hands
// one credit back per pop
// ==============================
`default_nettype none

module byte_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 i_sys_clk,
    input  logic                 rst_n_i,
    input  logic                 push_i,
    input  link_pkg::link_beat_t beat_i,
    input  logic                 pop_i,
    output logic                 not_empty_o,
    output link_pkg::link_beat_t head_o,
    output logic                 credit_o
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    link_pkg::link_beat_t mem [FIFO_DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic [CW-1:0]        count;

    // Wrap also works for depths that are not a power of two
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        if (ptr == AW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + AW'(1);
    endfunction

    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count    <= count + CW'(push_i) - CW'(pop_i);
            credit_o <= pop_i;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (push_i) begin
            mem[wr_ptr] <= beat_i;
        end
    end

    assign head_o      = mem[rd_ptr];
    assign not_empty_o = (count != '0);

    a_no_overflow : assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        push_i |-> (count < CW'(FIFO_DEPTH)) || pop_i);

    a_no_underflow : assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        pop_i |-> (count != '0));

endmodule

`default_nettype wire

// ==== src/cmd_bridge.sv ====
// ==============================
// Command bridge
// Parses host frames into single
// register accesses and responses
// ==============================
`default_nettype none

module cmd_bridge (
    input  logic                 i_sys_clk,
    input  logic                 rst_n_i,
    input  logic                 not_empty_i,
    input  link_pkg::link_beat_t head_i,
    output logic                 pop_o,
    output link_pkg::byte_t      tx_byte_o,
    output logic                 tx_load_o,
    output bus_pkg::bus_req_t    bus_req_o,
    input  bus_pkg::bus_rsp_t    bus_rsp_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR_HI,
        ST_ADDR_LO,
        ST_WDATA,
        ST_WAIT_ACK,
        ST_RDATA
    } state_t;

    state_t          state;
    logic            is_write;
    logic [1:0]      byte_cnt;
    logic            req_valid;
    logic            rx_first;
    logic            rx_byte;
    link_pkg::byte_t addr_hi;
    bus_pkg::addr_t  req_addr;
    bus_pkg::data_t  req_wdata;
    bus_pkg::data_t  rdata;

    // Bytes are consumed as soon as they arrive
    assign pop_o    = not_empty_i;
    assign rx_first = pop_o & head_i.first;
    assign rx_byte  = pop_o & ~head_i.first;

    // ==============================
    // Frame FSM
    // ==============================
    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            state     <= ST_IDLE;
            is_write  <= 1'b0;
            byte_cnt  <= '0;
            req_valid <= 1'b0;
            tx_load_o <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            tx_load_o <= 1'b0;
            if (rx_first) begin
                // Any first byte restarts parsing, unknown codes park in idle
                byte_cnt <= '0;
                is_write <= (head_i.data == bus_pkg::CMD_WRITE_REQ);
                if (head_i.data == bus_pkg::CMD_READ_REQ ||
                    head_i.data == bus_pkg::CMD_WRITE_REQ) begin
                    state <= ST_ADDR_HI;
                end else begin
                    state <= ST_IDLE;
                end
            end else begin
                case (state)
                    ST_ADDR_HI: begin
                        if (rx_byte) begin
                            state <= ST_ADDR_LO;
                        end
                    end
                    ST_ADDR_LO: begin
                        if (rx_byte && is_write) begin
                            state <= ST_WDATA;
                        end else if (rx_byte) begin
                            req_valid <= 1'b1;
                            state     <= ST_WAIT_ACK;
                        end
                    end
                    ST_WDATA: begin
                        if (rx_byte) begin
                            byte_cnt <= byte_cnt + 2'd1;
                            if (byte_cnt == 2'd3) begin
                                req_valid <= 1'b1;
                                state     <= ST_WAIT_ACK;
                            end
                        end
                    end
                    ST_WAIT_ACK: begin
                        if (bus_rsp_i.ack) begin
                            tx_load_o <= 1'b1;
                            byte_cnt  <= '0;
                            state     <= is_write ? ST_IDLE : ST_RDATA;
                        end
                    end
                    ST_RDATA: begin
                        // One read data byte per filler byte from the host
                        if (rx_byte) begin
                            tx_load_o <= 1'b1;
                            byte_cnt  <= byte_cnt + 2'd1;
                            if (byte_cnt == 2'd3) begin
                                state <= ST_IDLE;
                            end
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Address, data and response bytes
    always_ff @(posedge i_sys_clk) begin
        if (rx_byte && state == ST_ADDR_HI) begin
            addr_hi <= head_i.data;
        end
        if (rx_byte && state == ST_ADDR_LO) begin
            req_addr <= {addr_hi, head_i.data};
        end
        if (rx_byte && state == ST_WDATA) begin
            req_wdata <= {req_wdata[23:0], head_i.data};
        end
        if (state == ST_WAIT_ACK && bus_rsp_i.ack) begin
            tx_byte_o <= is_write ? bus_pkg::CMD_WRITE_RESP : bus_pkg::CMD_READ_RESP;
            rdata     <= bus_rsp_i.rdata;
        end
        if (rx_byte && state == ST_RDATA) begin
            tx_byte_o <= rdata[31:24];
            rdata     <= {rdata[23:0], 8'h00};
        end
    end

    always_comb begin
        bus_req_o.valid = req_valid;
        bus_req_o.write = is_write;
        bus_req_o.addr  = req_addr;
        bus_req_o.wdata = req_wdata;
    end

    a_ack_after_req : assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        bus_rsp_i.ack |-> $past(req_valid));

endmodule

`default_nettype wire

// ==== src/periph_regs.sv ====
// ==============================
// Peripheral registers
// LED register and version word
// ==============================
`default_nettype none

module periph_regs #(
    parameter int LED_WIDTH = 5
) (
    input  logic                 i_sys_clk,
    input  logic                 rst_n_i,
    input  bus_pkg::bus_req_t    bus_req_i,
    output bus_pkg::bus_rsp_t    bus_rsp_o,
    output logic [LED_WIDTH-1:0] led_o
);

    localparam int DW = $bits(bus_pkg::data_t);

    logic                 hit_led;
    logic                 hit_ver;
    logic [LED_WIDTH-1:0] led_q;
    logic                 ack_q;
    bus_pkg::data_t       rd_mux;
    bus_pkg::data_t       rdata_q;

    // Address decode
    assign hit_led = (bus_req_i.addr == bus_pkg::ADDR_LED);
    assign hit_ver = (bus_req_i.addr == bus_pkg::ADDR_VERSION);

    always_comb begin
        rd_mux = '0;
        if (hit_led) begin
            rd_mux = {{(DW - LED_WIDTH){1'b0}}, led_q};
        end else if (hit_ver) begin
            rd_mux = bus_pkg::VERSION_WORD;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            led_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req_i.valid;
            if (bus_req_i.valid && bus_req_i.write && hit_led) begin
                led_q <= bus_req_i.wdata[LED_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (bus_req_i.valid) begin
            rdata_q <= rd_mux;
        end
    end

    always_comb begin
        bus_rsp_o.ack   = ack_q;
        bus_rsp_o.rdata = rdata_q;
    end

    // Pads sink current, a set bit lights its LED
    assign led_o = ~led_q;

endmodule

`default_nettype wire

// ==== src/fc_io_top.sv ====
// ==============================
// Flight controller I/O core
// SPI command path to LED and
// version registers
// ==============================
`default_nettype none

module fc_io_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int LED_WIDTH  = 5
) (
    input  logic                 i_sys_clk,
    input  logic                 rst_n_i,
    input  logic                 spi_sclk_i,
    input  logic                 spi_cs_n_i,
    input  logic                 spi_mosi_i,
    output logic                 spi_miso_o,
    output logic [LED_WIDTH-1:0] led_o
);

    logic                 push;
    link_pkg::link_beat_t beat;
    logic                 credit;
    logic                 not_empty;
    link_pkg::link_beat_t head;
    logic                 pop;
    link_pkg::byte_t      tx_byte;
    logic                 tx_load;
    bus_pkg::bus_req_t    bus_req;
    bus_pkg::bus_rsp_t    bus_rsp;

    spi_byte_link #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_spi_byte_link (
        .i_sys_clk  (i_sys_clk),
        .rst_n_i    (rst_n_i),
        .spi_sclk_i (spi_sclk_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (spi_miso_o),
        .push_o     (push),
        .beat_o     (beat),
        .credit_i   (credit),
        .tx_byte_i  (tx_byte),
        .tx_load_i  (tx_load)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_byte_fifo (
        .i_sys_clk   (i_sys_clk),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .beat_i      (beat),
        .pop_i       (pop),
        .not_empty_o (not_empty),
        .head_o      (head),
        .credit_o    (credit)
    );

    cmd_bridge u_cmd_bridge (
        .i_sys_clk   (i_sys_clk),
        .rst_n_i     (rst_n_i),
        .not_empty_i (not_empty),
        .head_i      (head),
        .pop_o       (pop),
        .tx_byte_o   (tx_byte),
        .tx_load_o   (tx_load),
        .bus_req_o   (bus_req),
        .bus_rsp_i   (bus_rsp)
    );

    periph_regs #(
        .LED_WIDTH (LED_WIDTH)
    ) u_periph_regs (
        .i_sys_clk (i_sys_clk),
        .rst_n_i   (rst_n_i),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .led_o     (led_o)
    );

endmodule

`default_nettype wire

// ==== verif/tb_fc_io.sv ====
// ==============================
// Testbench for the I/O core
// SPI host model driving read and
// write frames into the LED and
// version registers
// ==============================
`default_nettype none

module tb_fc_io;

    timeunit 1ns;
    timeprecision 1ps;

    // System clocks per SPI half period, 200 ns SPI clock
    localparam int HALF_SCLK = 10;

    logic        sys_clk;
    logic        rst_n;
    logic        spi_sclk;
    logic        spi_cs_n;
    logic        spi_mosi;
    logic        spi_miso;
    logic [4:0]  led;
    logic [7:0]  frame_tx [0:7];
    logic [7:0]  frame_rx [0:7];
    logic [4:0]  led_model;
    integer      seed;
    int          errors;

    fc_io_top #(
        .FIFO_DEPTH (4),
        .LED_WIDTH  (5)
    ) dut_i (
        .i_sys_clk  (sys_clk),
        .rst_n_i    (rst_n),
        .spi_sclk_i (spi_sclk),
        .spi_cs_n_i (spi_cs_n),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso),
        .led_o      (led)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    // ==============================
    // Failure reporting
    // ==============================
    task automatic fail_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            fail_run();
        end
    endtask

    // ==============================
    // SPI host model, mode 0, MSB first
    // ==============================
    task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
        rx = '0;
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = tx[i];
            repeat (HALF_SCLK) @(negedge sys_clk);
            // MISO moved on the previous falling edge and is settled here
            rx = {rx[6:0], spi_miso};
            spi_sclk = 1'b1;
            repeat (HALF_SCLK) @(negedge sys_clk);
            spi_sclk = 1'b0;
        end
    endtask

    task automatic run_frame(input int n_bytes);
        logic [7:0] rx;
        spi_cs_n = 1'b0;
        repeat (HALF_SCLK) @(negedge sys_clk);
        for (int b = 0; b < n_bytes; b++) begin
            spi_xfer(frame_tx[b], rx);
            frame_rx[b] = rx;
        end
        repeat (HALF_SCLK) @(negedge sys_clk);
        spi_cs_n = 1'b1;
        repeat (4 * HALF_SCLK) @(negedge sys_clk);
    endtask

    task automatic spi_read(input logic [15:0] addr, output logic [7:0] code,
                            output logic [31:0] data);
        frame_tx[0] = bus_pkg::CMD_READ_REQ;
        frame_tx[1] = addr[15:8];
        frame_tx[2] = addr[7:0];
        for (int b = 3; b < 8; b++) begin
            frame_tx[b] = 8'h00;
        end
        run_frame(8);
        code = frame_rx[3];
        data = {frame_rx[4], frame_rx[5], frame_rx[6], frame_rx[7]};
    endtask

    task automatic spi_write(input logic [15:0] addr, input logic [31:0] data,
                             output logic [7:0] code);
        frame_tx[0] = bus_pkg::CMD_WRITE_REQ;
        frame_tx[1] = addr[15:8];
        frame_tx[2] = addr[7:0];
        frame_tx[3] = data[31:24];
        frame_tx[4] = data[23:16];
        frame_tx[5] = data[15:8];
        frame_tx[6] = data[7:0];
        frame_tx[7] = 8'h00;
        run_frame(8);
        code = frame_rx[7];
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset_state();
        @(negedge sys_clk);
        check_eq("led_o", led, 32'h1F);
        check_eq("spi_miso_o", spi_miso, 32'h0);
    endtask

    task automatic test_version_read();
        logic [7:0]  code;
        logic [31:0] data;
        spi_read(bus_pkg::ADDR_VERSION, code, data);
        for (int b = 0; b < 3; b++) begin
            check_eq("request slot byte", frame_rx[b], 32'h0);
        end
        check_eq("read response code", code, bus_pkg::CMD_READ_RESP);
        check_eq("version word", data, bus_pkg::VERSION_WORD);
    endtask

    task automatic write_and_read_led(input logic [31:0] word);
        logic [7:0]  code;
        logic [31:0] data;
        spi_write(bus_pkg::ADDR_LED, word, code);
        check_eq("write response code", code, bus_pkg::CMD_WRITE_RESP);
        led_model = word[4:0];
        check_eq("led_o", led, {27'h0, ~led_model});
        spi_read(bus_pkg::ADDR_LED, code, data);
        check_eq("read response code", code, bus_pkg::CMD_READ_RESP);
        check_eq("led read data", data, {27'h0, led_model});
    endtask

    task automatic test_random_led();
        logic [31:0] word;
        for (int n = 0; n < 10; n++) begin
            word = $random(seed);
            write_and_read_led(word);
        end
    endtask

    // Chip select rises after two of the four data bytes
    task automatic test_cut_frame();
        logic [7:0]  code;
        logic [31:0] data;
        frame_tx[0] = bus_pkg::CMD_WRITE_REQ;
        frame_tx[1] = 8'h00;
        frame_tx[2] = 8'h00;
        frame_tx[3] = 8'hAA;
        frame_tx[4] = 8'hBB;
        run_frame(5);
        check_eq("led_o", led, {27'h0, ~led_model});
        spi_read(bus_pkg::ADDR_LED, code, data);
        check_eq("read response code", code, bus_pkg::CMD_READ_RESP);
        check_eq("led read data", data, {27'h0, led_model});
    endtask

    task automatic test_bad_frames();
        logic [7:0]  code;
        logic [31:0] data;
        spi_read(16'h0100, code, data);
        check_eq("read response code", code, bus_pkg::CMD_READ_RESP);
        check_eq("unmapped read data", data, 32'h0);
        // Payload after the unknown code would flip every LED if it were parsed
        frame_tx[0] = 8'h55;
        frame_tx[1] = bus_pkg::CMD_WRITE_REQ;
        frame_tx[2] = 8'h00;
        frame_tx[3] = 8'h00;
        frame_tx[4] = 8'h00;
        frame_tx[5] = 8'h00;
        frame_tx[6] = 8'h00;
        frame_tx[7] = {3'b000, ~led_model};
        run_frame(8);
        for (int b = 0; b < 8; b++) begin
            check_eq("spi_miso_o byte", frame_rx[b], 32'h0);
        end
        check_eq("led_o", led, {27'h0, ~led_model});
    endtask

    initial begin
        errors    = 0;
        seed      = 79;
        led_model = 5'h00;
        rst_n     = 1'b0;
        spi_sclk  = 1'b0;
        spi_cs_n  = 1'b1;
        spi_mosi  = 1'b0;
        repeat (2) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n = 1'b1;

        test_reset_state();
        test_version_read();
        write_and_read_led(32'h0000_0015);
        test_random_led();
        test_cut_frame();
        test_bad_frames();

        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
src/link_pkg.sv
src/bus_pkg.sv
src/spi_byte_link.sv
src/byte_fifo.sv
src/cmd_bridge.sv
src/periph_regs.sv
src/fc_io_top.sv
verif/tb_fc_io.sv
